/* design/soc_defs.svh */
/*
 * Bus widths, memory size, region codes and counter widths for the
 * system controller. Include wherever these constants are needed.
 */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// wishbone bus
`define WB_AW 32
`define WB_DW 32
`define WB_SW 4

// bios block ram, 2048 words = 8 KiB at address 0
`define BRAM_WORDS 2048

// region code in the top address nibble
`define REGION_LED 4'hE

// reset delay counter, 2^12 cycles after lock
`define RST_CNT_BITS 12

// real-time tick, wraps every 2^16 cycles
`define RTC_BITS 16

`define LED_W 8

`endif

/* design/soc_pkg.sv */
/*
 * Shared types for the system controller bus: the address word with its
 * region and word views, and the region codes the decoder knows.
 */
`include "soc_defs.svh"

package soc_pkg;

	// region view, used by the decoder
	typedef struct packed {
		logic [3:0]         region;
		logic [`WB_AW-5:0]  offset;
	} wb_addr_rgn_t;

	// word view, used by the slaves
	typedef struct packed {
		logic [`WB_AW-3:0]  word;
		logic [1:0]         byte_ofs;
	} wb_addr_wrd_t;

	// one address word, decoded two ways
	typedef union packed {
		wb_addr_rgn_t rgn;
		wb_addr_wrd_t wrd;
	} wb_addr_u;

	typedef enum logic [3:0] {
		RGN_BIOS = 4'h0,
		RGN_LED  = `REGION_LED
	} region_e;

endpackage

/* design/wb_bus_if.sv */
/*
 * One decoded wishbone slave bus. The decoder takes the master modport,
 * each slave the slave modport. A request is cyc and stb both high.
 */
`timescale 1ns/100ps
`include "soc_defs.svh"

interface wb_bus_if;
	import soc_pkg::*;

	wb_addr_u           adr;
	logic [`WB_DW-1:0]  dat_w;
	logic [`WB_DW-1:0]  dat_r;
	logic [`WB_SW-1:0]  sel;
	logic               we;
	logic               stb;
	logic               cyc;
	logic               ack;

	modport master (
		output adr, dat_w, sel, we, stb, cyc,
		input  dat_r, ack
	);

	modport slave (
		input  adr, dat_w, sel, we, stb, cyc,
		output dat_r, ack
	);

endinterface

/* design/reset_sequencer.sv */
/*
 * Holds the internal reset low until the external reset is released and
 * the PLL reports lock, then waits 2^RST_CNT_BITS cycles before release.
 */
`timescale 1ns/100ps
`include "soc_defs.svh"

module reset_sequencer (
	input  logic sys_clk,
	input  logic sys_rstn,
	input  logic pll_locked_i,
	output logic rstn_o
);

	logic [1:0]               lock_q; // lock qualify stages
	logic [`RST_CNT_BITS-1:0] cnt;

	always_ff @(posedge sys_clk) begin
		if (!sys_rstn || !pll_locked_i) begin
			lock_q <= '0;
			cnt    <= '0;
		end else begin
			lock_q <= {lock_q[0], 1'b1};
			if (lock_q[1] && !rstn_o)
				cnt <= cnt + 1'b1; // saturates at all ones
		end
	end

	assign rstn_o = &cnt;

endmodule

/* design/rtc_tick.sv */
/*
 * Free-running real-time tick. Gives a one-cycle timer interrupt pulse
 * each time the counter wraps, every 2^RTC_BITS cycles.
 */
`timescale 1ns/100ps
`include "soc_defs.svh"

module rtc_tick (
	input  logic sys_clk,
	input  logic rstn_i,
	output logic tick_o
);

	logic [`RTC_BITS-1:0] rtc_cnt;

	always_ff @(posedge sys_clk) begin
		if (!rstn_i) begin
			rtc_cnt <= '0;
			tick_o  <= 1'b0;
		end else begin
			rtc_cnt <= rtc_cnt + 1'b1;
			// pulse lines up with the wrap to zero
			tick_o  <= &rtc_cnt;
		end
	end

endmodule

/* design/bus_decoder.sv */
/*
 * Address decoder for the single bus master. Picks the slave from the
 * region nibble, gates cyc to it alone and returns its read data and ack.
 * Unmapped addresses get no cyc, zero data and never an ack.
 */
`timescale 1ns/100ps
`include "soc_defs.svh"

module bus_decoder (
	input  soc_pkg::wb_addr_u  adr_i,
	input  logic [`WB_DW-1:0]  dat_i,
	input  logic [`WB_SW-1:0]  sel_i,
	input  logic               we_i,
	input  logic               stb_i,
	input  logic               cyc_i,
	output logic [`WB_DW-1:0]  dat_o,
	output logic               ack_o,
	wb_bus_if.master           bram_bus,
	wb_bus_if.master           led_bus
);
	import soc_pkg::*;

	localparam int BRAM_BYTES = `BRAM_WORDS * 4;

	region_e region;
	logic    cs_bram;
	logic    cs_led;

	assign region  = region_e'(adr_i.rgn.region);
	// bios space is the first 8 KiB of region 0
	assign cs_bram = (region == RGN_BIOS) && (adr_i.rgn.offset < BRAM_BYTES);
	assign cs_led  = (region == RGN_LED);

	// shared fields go to both slaves
	assign bram_bus.adr   = adr_i;
	assign bram_bus.dat_w = dat_i;
	assign bram_bus.sel   = sel_i;
	assign bram_bus.we    = we_i;
	assign bram_bus.stb   = stb_i;
	assign bram_bus.cyc   = cyc_i & cs_bram;

	assign led_bus.adr    = adr_i;
	assign led_bus.dat_w  = dat_i;
	assign led_bus.sel    = sel_i;
	assign led_bus.we     = we_i;
	assign led_bus.stb    = stb_i;
	assign led_bus.cyc    = cyc_i & cs_led;

	assign dat_o = cs_bram ? bram_bus.dat_r :
	               cs_led  ? led_bus.dat_r  : '0;

	assign ack_o = cs_bram ? bram_bus.ack :
	               cs_led  ? led_bus.ack  : 1'b0;

endmodule

/* design/bram_slave.sv */
/*
 * BIOS block RAM on the wishbone bus. Word addressed through the word
 * view of the address, byte-lane writes from sel, registered read data
 * and a single-cycle ack one clock after the request.
 */
`timescale 1ns/100ps
`include "soc_defs.svh"

module bram_slave (
	input  logic     sys_clk,
	input  logic     rstn_i,
	wb_bus_if.slave  bus
);

	localparam int ADR_BITS = $clog2(`BRAM_WORDS);

	logic [`WB_DW-1:0]   mem [0:`BRAM_WORDS-1];
	logic [ADR_BITS-1:0] idx;
	logic                req;
	logic                ack_q;

	assign idx = bus.adr.wrd.word[ADR_BITS-1:0];
	assign req = bus.cyc & bus.stb;

	// ack once per request, master drops stb after it
	always_ff @(posedge sys_clk) begin
		if (!rstn_i)
			ack_q <= 1'b0;
		else
			ack_q <= req & ~ack_q;
	end

	// write lands on the same edge that raises ack
	always_ff @(posedge sys_clk) begin
		if (req && !ack_q && bus.we) begin
			for (int i = 0; i < `WB_SW; i++) begin
				if (bus.sel[i])
					mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (req)
			bus.dat_r <= mem[idx]; // valid while ack high
	end

	assign bus.ack = ack_q;

endmodule

/* design/led_slave.sv */
/*
 * Debug LED register on the wishbone bus. Any offset in the region hits
 * the one register; byte lane 0 writes it and reads return it
 * zero-extended. Acks one clock after the request, as the RAM does.
 */
`timescale 1ns/100ps
`include "soc_defs.svh"

module led_slave (
	input  logic              sys_clk,
	input  logic              rstn_i,
	wb_bus_if.slave           bus,
	output logic [`LED_W-1:0] leds_o
);

	logic              req;
	logic              ack_q;
	logic [`LED_W-1:0] led_q;

	assign req = bus.cyc & bus.stb;

	always_ff @(posedge sys_clk) begin
		if (!rstn_i) begin
			ack_q <= 1'b0;
			led_q <= '0;
		end else begin
			ack_q <= req & ~ack_q;
			if (req && !ack_q && bus.we && bus.sel[0])
				led_q <= bus.dat_w[`LED_W-1:0];
		end
	end

	assign bus.dat_r = {{(`WB_DW-`LED_W){1'b0}}, led_q};
	assign bus.ack   = ack_q;
	assign leds_o    = led_q;

endmodule

/* design/sysctl_top.sv */
/*
 * System controller top. Reset sequencer, real-time tick, bus decoder,
 * BIOS RAM and debug LEDs, with the bus master on plain ports.
 */
`timescale 1ns/100ps
`include "soc_defs.svh"

module sysctl_top (
	input  logic              sys_clk,
	input  logic              sys_rstn,
	input  logic              pll_locked_i,
	input  logic [`WB_AW-1:0] wb_adr_i,
	input  logic [`WB_DW-1:0] wb_dat_i,
	input  logic [`WB_SW-1:0] wb_sel_i,
	input  logic              wb_we_i,
	input  logic              wb_stb_i,
	input  logic              wb_cyc_i,
	output logic [`WB_DW-1:0] wb_dat_o,
	output logic              wb_ack_o,
	output logic              irq_timer_o,
	output logic              ready_o,
	output logic [`LED_W-1:0] leds_o
);

	logic rstn; // internal reset, released after lock delay

	wb_bus_if bram_bus ();
	wb_bus_if led_bus ();

	reset_sequencer u_reset (
		.sys_clk      (sys_clk),
		.sys_rstn     (sys_rstn),
		.pll_locked_i (pll_locked_i),
		.rstn_o       (rstn)
	);

	rtc_tick u_rtc (
		.sys_clk (sys_clk),
		.rstn_i  (rstn),
		.tick_o  (irq_timer_o)
	);

	// combinational, adds no cycle to the ack path
	bus_decoder u_decode (
		.adr_i    (wb_adr_i),
		.dat_i    (wb_dat_i),
		.sel_i    (wb_sel_i),
		.we_i     (wb_we_i),
		.stb_i    (wb_stb_i),
		.cyc_i    (wb_cyc_i),
		.dat_o    (wb_dat_o),
		.ack_o    (wb_ack_o),
		.bram_bus (bram_bus.master),
		.led_bus  (led_bus.master)
	);

	bram_slave u_bram (
		.sys_clk (sys_clk),
		.rstn_i  (rstn),
		.bus     (bram_bus.slave)
	);

	led_slave u_led (
		.sys_clk (sys_clk),
		.rstn_i  (rstn),
		.bus     (led_bus.slave),
		.leds_o  (leds_o)
	);

	assign ready_o = rstn;

endmodule

/* tb/tb_sysctl.sv */
/*
 * Testbench for the system controller top. Checks reset sequencing, then
 * runs a stimulus table of bus writes and reads over the BIOS RAM and the
 * LED register, probes unmapped space and measures the timer tick.
 */
`timescale 1ns/100ps
`include "soc_defs.svh"

module tb_sysctl;

	localparam int ACK_TIMEOUT  = 16;
	localparam int RST_TIMEOUT  = 8192;
	localparam int TICK_PERIOD  = 1 << `RTC_BITS;
	localparam int TICK_TIMEOUT = 3 * TICK_PERIOD;
	// first edge to see lock plus 2^RST_CNT_BITS more edges
	localparam int RST_DELAY    = (1 << `RST_CNT_BITS) + 1;

	typedef struct {
		logic [`WB_AW-1:0] adr;
		logic [`WB_DW-1:0] dat;
		logic [`WB_SW-1:0] sel;
		logic              we;
		logic [`WB_DW-1:0] exp;   // expected read data
		logic [`LED_W-1:0] led;   // expected leds_o after the step
	} step_t;

	logic              sys_clk;
	logic              sys_rstn;
	logic              pll_locked_i;
	logic [`WB_AW-1:0] wb_adr_i;
	logic [`WB_DW-1:0] wb_dat_i;
	logic [`WB_SW-1:0] wb_sel_i;
	logic              wb_we_i;
	logic              wb_stb_i;
	logic              wb_cyc_i;
	logic [`WB_DW-1:0] wb_dat_o;
	logic              wb_ack_o;
	logic              irq_timer_o;
	logic              ready_o;
	logic [`LED_W-1:0] leds_o;

	step_t             steps[$];
	logic [`WB_DW-1:0] ram_model [int]; // keyed by word index
	logic [`LED_W-1:0] led_model;
	logic [`WB_DW-1:0] rdat;
	int                seed;
	int                errors = 0;
	int                nchecks = 0;
	int                cyc_cnt = 0;
	int                ready_cycle = 0;
	int                tick_cycles[$];

	sysctl_top DUT (
		.sys_clk      (sys_clk),
		.sys_rstn     (sys_rstn),
		.pll_locked_i (pll_locked_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_sel_i     (wb_sel_i),
		.wb_we_i      (wb_we_i),
		.wb_stb_i     (wb_stb_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.irq_timer_o  (irq_timer_o),
		.ready_o      (ready_o),
		.leds_o       (leds_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) cyc_cnt <= cyc_cnt + 1;

	// cycle number of every high sample of the timer irq
	always @(negedge sys_clk) begin
		if (irq_timer_o === 1'b1)
			tick_cycles.push_back(cyc_cnt);
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
	                           input string what);
		nchecks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t ns: %s, got %h, expected %h",
			         $time, what, actual, expected);
		end
	endtask

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
	                                            input logic [31:0] new_w,
	                                            input logic [3:0] sel);
		logic [31:0] w;
		w = old_w;
		for (int i = 0; i < 4; i++)
			if (sel[i])
				w[8*i +: 8] = new_w[8*i +: 8];
		return w;
	endfunction

	function automatic bit is_led(input logic [31:0] adr);
		return adr[31:28] == `REGION_LED;
	endfunction

	task automatic add_write(input logic [31:0] adr, input logic [31:0] dat,
	                         input logic [3:0] sel);
		step_t s;
		int    w;
		w = adr[12:2];
		if (is_led(adr)) begin
			if (sel[0])
				led_model = dat[`LED_W-1:0];
		end else begin
			ram_model[w] = merge_bytes(ram_model.exists(w) ? ram_model[w] : '0, dat, sel);
		end
		s = '{adr, dat, sel, 1'b1, '0, led_model};
		steps.push_back(s);
	endtask

	task automatic add_read(input logic [31:0] adr);
		step_t s;
		logic [31:0] e;
		e = is_led(adr) ? {{(`WB_DW-`LED_W){1'b0}}, led_model} : ram_model[adr[12:2]];
		s = '{adr, '0, 4'hF, 1'b0, e, led_model};
		steps.push_back(s);
	endtask

	task automatic build_table;
		led_model = '0;
		add_write(32'h0000_0000, $random(seed), 4'hF);  // first word
		add_write(32'h0000_0004, $random(seed), 4'hF);
		add_write(32'h0000_0100, 32'h1122_3344, 4'hF);
		add_write(32'h0000_1000, $random(seed), 4'hF);
		add_write(32'h0000_1FFC, $random(seed), 4'hF);  // last word
		add_read(32'h0000_0000);
		add_read(32'h0000_0004);
		add_read(32'h0000_0100);
		add_read(32'h0000_1000);
		add_read(32'h0000_1FFC);
		// byte lanes
		add_write(32'h0000_0100, 32'hAABB_CCDD, 4'b0101);
		add_read(32'h0000_0100);
		add_write(32'h0000_0100, $random(seed), 4'b1000);
		add_write(32'h0000_0100, $random(seed), 4'b0010);
		add_read(32'h0000_0100);
		add_write(32'h0000_1FFC, $random(seed), 4'b0011);
		add_read(32'h0000_1FFC);
		// led register at assorted offsets in region E
		add_write(32'hE000_0000, 32'h0000_00A5, 4'b0001);
		add_read(32'hE000_0000);
		add_write(32'hE000_0010, 32'h0000_005A, 4'b1110); // lane 0 off so leds hold
		add_read(32'hE123_4568);
		add_write(32'hEFFF_FFFC, 32'hFFFF_FF3C, 4'b0001);
		add_read(32'hE000_0004);
		add_read(32'h0000_0000); // ram untouched by led writes
	endtask

	// starts and ends on a falling edge
	task automatic bus_access(input logic [31:0] adr, input logic [31:0] wdat,
	                          input logic [3:0] sel, input logic we,
	                          output logic [31:0] dat);
		int n;
		n = 0;
		dat = '0;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		wb_sel_i = sel;
		wb_we_i  = we;
		wb_stb_i = 1'b1;
		wb_cyc_i = 1'b1;
		while (wb_ack_o !== 1'b1 && n < ACK_TIMEOUT) begin
			@(negedge sys_clk);
			n++;
		end
		if (wb_ack_o !== 1'b1) begin
			errors++;
			$display("timeout: no ack for the access at address %h", adr);
		end else begin
			dat = wb_dat_o;
			check_value(n, 1, $sformatf("ack latency at %h", adr));
		end
		wb_stb_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_we_i  = 1'b0;
		@(negedge sys_clk); // stb low for one cycle
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
	                         input logic [3:0] sel);
		logic [31:0] unused;
		bus_access(adr, dat, sel, 1'b1, unused);
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
		bus_access(adr, '0, 4'hF, 1'b0, dat);
	endtask

	// ack must stay low for 8 cycles in unmapped space
	task automatic probe_unmapped(input logic [31:0] adr);
		wb_adr_i = adr;
		wb_sel_i = 4'hF;
		wb_we_i  = 1'b0;
		wb_stb_i = 1'b1;
		wb_cyc_i = 1'b1;
		repeat (8) begin
			@(negedge sys_clk);
			check_value(wb_ack_o, 1'b0, $sformatf("ack from unmapped %h", adr));
			check_value(wb_dat_o, '0, $sformatf("read data from unmapped %h", adr));
		end
		wb_stb_i = 1'b0;
		wb_cyc_i = 1'b0;
		@(negedge sys_clk);
	endtask

	task automatic check_idle_outputs;
		check_value(wb_ack_o, 1'b0, "wb_ack_o before ready");
		check_value(irq_timer_o, 1'b0, "irq_timer_o before ready");
		check_value(leds_o, '0, "leds_o before ready");
	endtask

	task automatic check_reset;
		int n;
		repeat (16) begin
			@(negedge sys_clk);
			check_value(ready_o, 1'b0, "ready_o while pll unlocked");
			check_idle_outputs();
		end
		pll_locked_i = 1'b1;
		n = 0;
		while (ready_o !== 1'b1 && n < RST_TIMEOUT) begin
			@(negedge sys_clk);
			n++;
			if (ready_o !== 1'b1)
				check_idle_outputs();
		end
		if (ready_o !== 1'b1) begin
			errors++;
			$display("timeout: ready_o never rose after pll lock");
		end else begin
			ready_cycle = cyc_cnt;
			check_value(n, RST_DELAY, "cycles from lock to ready_o");
		end
	endtask

	task automatic check_ticks;
		int n;
		n = 0;
		while (tick_cycles.size() < 2 && n < TICK_TIMEOUT) begin
			@(negedge sys_clk);
			n++;
		end
		repeat (2) @(negedge sys_clk); // a stretched pulse shows up here
		if (tick_cycles.size() < 2) begin
			errors++;
			$display("timeout: fewer than two timer ticks were seen");
		end else begin
			check_value(tick_cycles.size(), 2, "timer irq high samples");
			check_value(tick_cycles[0] - ready_cycle, TICK_PERIOD, "first tick delay");
			check_value(tick_cycles[1] - tick_cycles[0], TICK_PERIOD, "tick period");
		end
	endtask

	initial begin
		sys_rstn     = 1'b0;
		pll_locked_i = 1'b0;
		wb_adr_i     = '0;
		wb_dat_i     = '0;
		wb_sel_i     = '0;
		wb_we_i      = 1'b0;
		wb_stb_i     = 1'b0;
		wb_cyc_i     = 1'b0;
		seed         = 32'h52a8;
		build_table();

		repeat (4) @(negedge sys_clk);
		sys_rstn = 1'b1;
		check_reset();

		foreach (steps[i]) begin
			if (steps[i].we) begin
				bus_write(steps[i].adr, steps[i].dat, steps[i].sel);
			end else begin
				bus_read(steps[i].adr, rdat);
				check_value(rdat, steps[i].exp, $sformatf("read data at %h", steps[i].adr));
			end
			check_value(leds_o, steps[i].led, $sformatf("leds_o after step %0d", i));
		end

		probe_unmapped(32'h5000_0000);
		probe_unmapped(32'h0000_2000); // just past the ram
		bus_read(32'h0000_1FFC, rdat);
		check_value(rdat, ram_model[11'h7FF], "read after unmapped probes");

		check_ticks();

		$display("checks: %0d, errors: %0d", nchecks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* files.f */
+incdir+design
design/soc_pkg.sv
design/wb_bus_if.sv
design/reset_sequencer.sv
design/rtc_tick.sv
design/bus_decoder.sv
design/bram_slave.sv
design/led_slave.sv
design/sysctl_top.sv
tb/tb_sysctl.sv
